// ==== common/stack_cpu_pkg.sv ====
package stack_cpu_pkg;

    parameter int data_len = 8;
    parameter int addr_len = 8;

    typedef logic [data_len-1:0] data_word_t;
    typedef logic [addr_len-1:0] mem_addr_t;
    typedef logic [3:0]          opcode_t;

    // Transfer unit opcodes.
    localparam opcode_t OP_PUSH  = 4'd0;
    localparam opcode_t OP_LOAD  = 4'd1;
    localparam opcode_t OP_STORE = 4'd2;

    // ALU unit opcodes.
    localparam opcode_t OP_ADD = 4'd8;
    localparam opcode_t OP_SUB = 4'd9;
    localparam opcode_t OP_AND = 4'd10;
    localparam opcode_t OP_XOR = 4'd11;

    typedef enum logic [2:0] {
        XFER_IDLE,
        XFER_PUSH,
        XFER_POP,
        XFER_LOAD,
        XFER_WAIT,
        XFER_STORE
    } xfer_state_t;

    typedef enum logic [1:0] {
        ALU_IDLE,
        ALU_POP_B,
        ALU_POP_A,
        ALU_PUSH
    } alu_state_t;

endpackage

// ==== dv/stack_cpu_assert.sv ====
`timescale 1ns/1ps

module stack_cpu_assert (
    input logic clk,
    input logic rstn,
    input logic xfer_push,
    input logic xfer_pop,
    input logic alu_push,
    input logic alu_pop,
    input logic push,
    input logic pop,
    input logic done,
    input logic mem_rd_en,
    input logic mem_wr_en
);
    // One instruction at a time, so only one unit may ask for the stack.
    a_one_requester: assert property (@(posedge clk) disable iff (!rstn)
        !((xfer_push || xfer_pop) && (alu_push || alu_pop)))
        else $error("both units request the stack port");

    a_push_pop: assert property (@(posedge clk) disable iff (!rstn) !(push && pop))
        else $error("stack push and pop in the same cycle");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else $error("done held high for two cycles");

    a_ram_access: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_rd_en && mem_wr_en))
        else $error("RAM read and write in the same cycle");

endmodule

bind stack_cpu stack_cpu_assert u_assert (
    .clk(clk), .rstn(rstn),
    .xfer_push(xfer_push), .xfer_pop(xfer_pop),
    .alu_push(alu_push), .alu_pop(alu_pop),
    .push(push), .pop(pop), .done(done),
    .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en)
);

// ==== dv/stack_cpu_patterns.txt ====
# Columns: test name, opcode, operand, expected top, expected count, expected fault (hex).
# Opcodes: 0 push, 1 load, 2 store, 8 add, 9 sub, a and, b xor.
push_a        0 12 12 1 0
push_b        0 34 34 2 0
store_b       2 40 12 1 0
load_b        1 40 34 2 0
add_ab        8 00 46 1 0
push_sub      0 0f 0f 2 0
sub_ab        9 00 37 1 0
push_wrap     0 c8 c8 2 0
sub_wrap      9 00 6f 1 0
push_mask     0 3c 3c 2 0
and_ab        a 00 2c 1 0
push_ones     0 ff ff 2 0
xor_ab        b 00 d3 1 0
store_res     2 05 00 0 0
store_empty   2 06 00 0 1
load_zero     1 06 00 1 1
load_res      1 05 d3 2 1
fill_3        0 01 01 3 1
fill_4        0 02 02 4 1
fill_5        0 03 03 5 1
fill_6        0 04 04 6 1
fill_7        0 05 05 7 1
fill_8        0 06 06 8 1
overflow      0 77 06 8 1

// ==== dv/stack_cpu_tb.sv ====
`timescale 1ns/1ps

module stack_cpu_tb;
    import stack_cpu_pkg::*;

    localparam int STACK_DEPTH = 8;
    localparam int CNT_W       = $clog2(STACK_DEPTH + 1);

    logic             clk = 1'b0;
    logic             rstn;
    logic             start;
    opcode_t          opcode;
    data_word_t       operand;
    logic             done;
    data_word_t       stack_top;
    logic [CNT_W-1:0] stack_count;
    logic             fault;

    string       names[$];
    logic [31:0] ops[$];
    logic [31:0] operands[$];
    logic [31:0] exp_tops[$];
    logic [31:0] exp_counts[$];
    logic [31:0] exp_faults[$];

    int          test_errors;
    int          passed;
    int          failed;
    int unsigned cycles      = 0;
    int unsigned cycle_limit = 20;
    bit          file_ok;

    stack_cpu #(.STACK_DEPTH(STACK_DEPTH)) uut (
        .clk(clk), .rstn(rstn), .start(start), .opcode(opcode), .operand(operand),
        .done(done), .stack_top(stack_top), .stack_count(stack_count), .fault(fault)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic load_patterns(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] f_op, f_opd, f_top, f_cnt, f_flt;
        ok = 1'b0;
        fd = $fopen("dv/stack_cpu_patterns.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h",
                                name, f_op, f_opd, f_top, f_cnt, f_flt);
                    if (n == 6) begin
                        names.push_back(name);
                        ops.push_back(f_op);
                        operands.push_back(f_opd);
                        exp_tops.push_back(f_top);
                        exp_counts.push_back(f_cnt);
                        exp_faults.push_back(f_flt);
                    end
                end
            end
            $fclose(fd);
            ok = (names.size() > 0);
        end
    endtask

    // Cycles from the start edge until done is seen high.
    function automatic int unsigned done_latency(input logic [31:0] op);
        case (opcode_t'(op))
            OP_PUSH:  done_latency = 2;
            OP_STORE: done_latency = 3;
            default:  done_latency = 4;
        endcase
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %0h, actual %0h", test, what, expected, actual);
            test_errors++;
        end
    endtask

    // Issue one instruction, wait for done, check state a cycle later.
    task automatic run_test(input int idx);
        int waited;
        test_errors = 0;
        @(negedge clk);
        start   = 1'b1;
        opcode  = opcode_t'(ops[idx]);
        operand = data_word_t'(operands[idx]);
        @(negedge clk);
        start  = 1'b0;
        waited = 1;
        while (done !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            $display("%s: done did not arrive within 10 cycles", names[idx]);
            test_errors++;
        end else begin
            check_value(names[idx], "latency", 32'(done_latency(ops[idx])), 32'(waited));
            @(negedge clk);
            check_value(names[idx], "top", exp_tops[idx], 32'(stack_top));
            check_value(names[idx], "count", exp_counts[idx], 32'(stack_count));
            check_value(names[idx], "fault", exp_faults[idx], 32'(fault));
        end
        if (test_errors == 0) begin
            $display("PASS %s", names[idx]);
            passed++;
        end else begin
            $display("FAIL %s", names[idx]);
            failed++;
        end
    endtask

    initial begin
        rstn    = 1'b0;
        start   = 1'b0;
        opcode  = OP_PUSH;
        operand = '0;
        passed  = 0;
        failed  = 0;
        load_patterns(file_ok);
        if (!file_ok) begin
            $display("Could not read any pattern from dv/stack_cpu_patterns.txt");
            failed++;
        end else begin
            cycle_limit = 20 * names.size() + 20;
            repeat (2) @(negedge clk);
            rstn = 1'b1;
            for (int i = 0; i < names.size(); i++) begin
                run_test(i);
            end
        end
        $display("Tests: %0d run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/stack_cpu_pkg.sv
source/stack_memory.sv
source/stack_arbiter.sv
source/data_ram.sv
stack_transfer_unit/stack_transfer_unit.sv
stack_alu_unit/stack_alu_unit.sv
source/stack_cpu.sv
dv/stack_cpu_assert.sv
dv/stack_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the stack_cpu testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module stack_cpu_tb \
    -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vstack_cpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0

// ==== source/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int DATA_LEN = stack_cpu_pkg::data_len,
    parameter int ADDR_LEN = stack_cpu_pkg::addr_len
) (
    input  logic                      clk,
    input  logic                      rd_en,
    input  logic                      wr_en,
    input  stack_cpu_pkg::mem_addr_t  addr,
    input  stack_cpu_pkg::data_word_t wr_data,
    output stack_cpu_pkg::data_word_t rd_data
);
    localparam int DEPTH = 2 ** ADDR_LEN;

    logic [DATA_LEN-1:0] mem [DEPTH];

    // Read data appears the cycle after rd_en.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

// ==== source/stack_arbiter.sv ====
`timescale 1ns/1ps

module stack_arbiter (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      xfer_push,
    input  logic                      xfer_pop,
    input  stack_cpu_pkg::data_word_t xfer_data,
    input  logic                      alu_push,
    input  logic                      alu_pop,
    input  stack_cpu_pkg::data_word_t alu_data,
    output logic                      xfer_grant,
    output logic                      alu_grant,
    output logic                      push,
    output logic                      pop,
    output stack_cpu_pkg::data_word_t push_data
);
    logic xfer_req;
    logic alu_req;
    logic owner_alu_q;

    assign xfer_req = xfer_push | xfer_pop;
    assign alu_req  = alu_push | alu_pop;

    // ALU keeps the port across its pop and push sequence.
    always_comb begin
        xfer_grant = 1'b0;
        alu_grant  = 1'b0;
        if (owner_alu_q && alu_req) begin
            alu_grant = 1'b1;
        end else if (xfer_req) begin
            xfer_grant = 1'b1;
        end else if (alu_req) begin
            alu_grant = 1'b1;
        end
    end

    assign push      = (xfer_grant & xfer_push) | (alu_grant & alu_push);
    assign pop       = (xfer_grant & xfer_pop) | (alu_grant & alu_pop);
    assign push_data = xfer_grant ? xfer_data : (alu_grant ? alu_data : '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            owner_alu_q <= 1'b0;
        end else begin
            owner_alu_q <= alu_grant;
        end
    end

endmodule

// ==== source/stack_cpu.sv ====
`timescale 1ns/1ps

module stack_cpu #(
    parameter int DATA_LEN    = stack_cpu_pkg::data_len,
    parameter int ADDR_LEN    = stack_cpu_pkg::addr_len,
    parameter int STACK_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             start,
    input  stack_cpu_pkg::opcode_t           opcode,
    input  stack_cpu_pkg::data_word_t        operand,
    output logic                             done,
    output stack_cpu_pkg::data_word_t        stack_top,
    output logic [$clog2(STACK_DEPTH+1)-1:0] stack_count,
    output logic                             fault
);
    import stack_cpu_pkg::*;

    logic       xfer_push, xfer_pop, xfer_grant, xfer_done;
    logic       alu_push, alu_pop, alu_grant, alu_done;
    logic       push, pop, mem_rd_en, mem_wr_en;
    data_word_t xfer_data, alu_data, push_data, pop_data;
    data_word_t mem_wr_data, mem_rd_data;
    mem_addr_t  mem_addr;

    assign done = xfer_done | alu_done;

    stack_transfer_unit #(.ADDR_LEN(ADDR_LEN)) u_xfer (
        .clk(clk), .rstn(rstn), .start(start), .opcode(opcode), .operand(operand),
        .grant(xfer_grant), .push_req(xfer_push), .pop_req(xfer_pop),
        .push_data(xfer_data), .pop_data(pop_data),
        .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en), .mem_addr(mem_addr),
        .mem_wr_data(mem_wr_data), .mem_rd_data(mem_rd_data), .done(xfer_done)
    );

    stack_alu_unit #(.DATA_LEN(DATA_LEN)) u_alu (
        .clk(clk), .rstn(rstn), .start(start), .opcode(opcode), .grant(alu_grant),
        .push_req(alu_push), .pop_req(alu_pop), .push_data(alu_data),
        .pop_data(pop_data), .done(alu_done)
    );

    stack_arbiter u_arb (
        .clk(clk), .rstn(rstn),
        .xfer_push(xfer_push), .xfer_pop(xfer_pop), .xfer_data(xfer_data),
        .alu_push(alu_push), .alu_pop(alu_pop), .alu_data(alu_data),
        .xfer_grant(xfer_grant), .alu_grant(alu_grant),
        .push(push), .pop(pop), .push_data(push_data)
    );

    stack_memory #(.DATA_LEN(DATA_LEN), .STACK_DEPTH(STACK_DEPTH)) u_stack (
        .clk(clk), .rstn(rstn), .push(push), .pop(pop), .push_data(push_data),
        .pop_data(pop_data), .top_data(stack_top), .count(stack_count), .fault(fault)
    );

    data_ram #(.DATA_LEN(DATA_LEN), .ADDR_LEN(ADDR_LEN)) u_ram (
        .clk(clk), .rd_en(mem_rd_en), .wr_en(mem_wr_en), .addr(mem_addr),
        .wr_data(mem_wr_data), .rd_data(mem_rd_data)
    );

endmodule

// ==== source/stack_memory.sv ====
`timescale 1ns/1ps

module stack_memory #(
    parameter int DATA_LEN    = stack_cpu_pkg::data_len,
    parameter int STACK_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             push,
    input  logic                             pop,
    input  stack_cpu_pkg::data_word_t        push_data,
    output stack_cpu_pkg::data_word_t        pop_data,
    output stack_cpu_pkg::data_word_t        top_data,
    output logic [$clog2(STACK_DEPTH+1)-1:0] count,
    output logic                             fault
);
    localparam int CNT_W = $clog2(STACK_DEPTH + 1);
    localparam int IDX_W = $clog2(STACK_DEPTH);

    logic [DATA_LEN-1:0] mem [STACK_DEPTH];
    logic                full;
    logic                empty;
    logic [IDX_W-1:0]    wr_idx;
    logic [IDX_W-1:0]    top_idx;

    assign full    = (count == CNT_W'(STACK_DEPTH));
    assign empty   = (count == '0);
    assign wr_idx  = IDX_W'(count);
    assign top_idx = IDX_W'(count - 1'b1);

    assign top_data = empty ? '0 : mem[top_idx];

    // Pushes into a full stack are dropped.
    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_idx] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count    <= '0;
            fault    <= 1'b0;
            pop_data <= '0;
        end else if (push) begin
            if (full) begin
                fault <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            // Empty pop returns zero.
            if (empty) begin
                pop_data <= '0;
                fault    <= 1'b1;
            end else begin
                pop_data <= top_data;
                count    <= count - 1'b1;
            end
        end
    end

endmodule

// ==== stack_alu_unit/stack_alu_unit.sv ====
`timescale 1ns/1ps

module stack_alu_unit #(
    parameter int DATA_LEN = stack_cpu_pkg::data_len
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      start,
    input  stack_cpu_pkg::opcode_t    opcode,
    input  logic                      grant,
    output logic                      push_req,
    output logic                      pop_req,
    output stack_cpu_pkg::data_word_t push_data,
    input  stack_cpu_pkg::data_word_t pop_data,
    output logic                      done
);
    import stack_cpu_pkg::*;

    alu_state_t          state;
    opcode_t             op_q;
    logic [DATA_LEN-1:0] b_q;
    logic [DATA_LEN-1:0] result;

    // Operand a sits in pop_data after the second pop.
    always_comb begin
        case (op_q)
            OP_ADD:  result = pop_data + b_q;
            OP_SUB:  result = pop_data - b_q;
            OP_AND:  result = pop_data & b_q;
            default: result = pop_data ^ b_q;
        endcase
    end

    assign push_data = push_req ? result : '0;

    always_ff @(posedge clk) begin
        if (state == ALU_POP_A && grant) begin
            b_q <= pop_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= ALU_IDLE;
            op_q     <= OP_ADD;
            push_req <= 1'b0;
            pop_req  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ALU_IDLE: begin
                    if (start && opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR}) begin
                        op_q  <= opcode;
                        state <= ALU_POP_B;
                    end
                end
                ALU_POP_B: begin
                    if (!pop_req) begin
                        pop_req <= 1'b1;
                    end else if (grant) begin
                        state <= ALU_POP_A;
                    end
                end
                // Second pop then straight into the push.
                ALU_POP_A: begin
                    if (grant) begin
                        pop_req  <= 1'b0;
                        push_req <= 1'b1;
                        done     <= 1'b1;
                        state    <= ALU_PUSH;
                    end
                end
                ALU_PUSH: begin
                    if (grant) begin
                        push_req <= 1'b0;
                        state    <= ALU_IDLE;
                    end
                end
                default: state <= ALU_IDLE;
            endcase
        end
    end

endmodule

// ==== stack_transfer_unit/stack_transfer_unit.sv ====
`timescale 1ns/1ps

module stack_transfer_unit #(
    parameter int ADDR_LEN = stack_cpu_pkg::addr_len
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      start,
    input  stack_cpu_pkg::opcode_t    opcode,
    input  stack_cpu_pkg::data_word_t operand,
    input  logic                      grant,
    output logic                      push_req,
    output logic                      pop_req,
    output stack_cpu_pkg::data_word_t push_data,
    input  stack_cpu_pkg::data_word_t pop_data,
    output logic                      mem_rd_en,
    output logic                      mem_wr_en,
    output stack_cpu_pkg::mem_addr_t  mem_addr,
    output stack_cpu_pkg::data_word_t mem_wr_data,
    input  stack_cpu_pkg::data_word_t mem_rd_data,
    output logic                      done
);
    import stack_cpu_pkg::*;

    xfer_state_t state;

    // Store data is the word popped just before the write.
    assign mem_wr_data = mem_wr_en ? pop_data : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= XFER_IDLE;
            push_req  <= 1'b0;
            pop_req   <= 1'b0;
            push_data <= '0;
            mem_rd_en <= 1'b0;
            mem_wr_en <= 1'b0;
            mem_addr  <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                XFER_IDLE: begin
                    if (start) begin
                        case (opcode)
                            OP_PUSH:  state <= XFER_PUSH;
                            OP_LOAD:  state <= XFER_LOAD;
                            OP_STORE: state <= XFER_POP;
                            default:  state <= XFER_IDLE;
                        endcase
                    end
                end
                XFER_LOAD: begin
                    mem_rd_en <= 1'b1;
                    mem_addr  <= operand[ADDR_LEN-1:0];
                    state     <= XFER_WAIT;
                end
                // Read word lands in mem_rd_data here.
                XFER_WAIT: begin
                    mem_rd_en <= 1'b0;
                    mem_addr  <= '0;
                    state     <= XFER_PUSH;
                end
                XFER_PUSH: begin
                    if (!push_req) begin
                        push_req  <= 1'b1;
                        push_data <= (opcode == OP_LOAD) ? mem_rd_data : operand;
                        done      <= 1'b1;
                    end else if (grant) begin
                        push_req  <= 1'b0;
                        push_data <= '0;
                        state     <= XFER_IDLE;
                    end
                end
                XFER_POP: begin
                    if (!pop_req) begin
                        pop_req <= 1'b1;
                    end else if (grant) begin
                        pop_req   <= 1'b0;
                        mem_wr_en <= 1'b1;
                        mem_addr  <= operand[ADDR_LEN-1:0];
                        done      <= 1'b1;
                        state     <= XFER_STORE;
                    end
                end
                XFER_STORE: begin
                    mem_wr_en <= 1'b0;
                    mem_addr  <= '0;
                    state     <= XFER_IDLE;
                end
                default: state <= XFER_IDLE;
            endcase
        end
    end

endmodule
